// ==== Makefile ====
TOP = tb_spim
LOG = sim.log

all: run

obj_dir/V$(TOP): build.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

// ==== build.f ====
+incdir+.
spim_pkg.sv
spim_fifo.sv
spim_clkgen.sv
spim_ctrl.sv
spim_txrx.sv
spim_top.sv
tb_clkgen.sv
tb_spi_device.sv
tb_spim.sv

// ==== spim_clkgen.sv ====
`timescale 1ns/1ns
`include "spim_config.svh"

module spim_clkgen
(
    input  logic                      sys_clk_i,
    input  logic                      rst_n_i,
    input  logic [`SPIM_CLKDIV_W-1:0] clkdiv_i,
    input  logic                      run_i,
    output logic                      spi_clk_o,
    output logic                      rise_o,
    output logic                      fall_o
);

    logic [`SPIM_CLKDIV_W-1:0] cnt;
    logic                      active;
    logic                      toggle;

    // A high phase always runs to its end, so the clock parks low
    assign active = run_i | spi_clk_o;
    assign toggle = active && (cnt >= clkdiv_i);

    // Edge strobes lead the clock register by one cycle
    assign rise_o = toggle & ~spi_clk_o;
    assign fall_o = toggle & spi_clk_o;

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt       <= '0;
            spi_clk_o <= 1'b0;
        end
        else if (!active)
        begin
            cnt <= '0;
        end
        else if (toggle)
        begin
            cnt       <= '0;
            spi_clk_o <= ~spi_clk_o;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== spim_config.svh ====
`ifndef SPIM_CONFIG_SVH
`define SPIM_CONFIG_SVH

// Word width of commands, TX data and RX data
`define SPIM_DATA_W     32

// Depth of the command FIFO and the TX data FIFO
`define SPIM_FIFO_DEPTH 8

// Clock divider setting width
`define SPIM_CLKDIV_W   8

// Chip select count
`define SPIM_NUM_CS     4

// Command word fields
`define SPIM_OPCODE_W   4
`define SPIM_LEN_W      8
`define SPIM_CMD_W      16

`endif

// ==== spim_ctrl.sv ====
`timescale 1ns/1ns
`include "spim_config.svh"

module spim_ctrl
(
    input  logic                      sys_clk_i,
    input  logic                      rst_n_i,

    input  spim_pkg::spim_cmd_u       cmd_i,
    input  logic                      cmd_empty_i,
    output logic                      cmd_pop_o,

    output logic [`SPIM_CLKDIV_W-1:0] clkdiv_o,

    output logic                      xfer_start_o,
    output spim_pkg::spim_xfer_t      xfer_o,
    input  logic                      xfer_done_i,

    output logic [`SPIM_NUM_CS-1:0]   spi_csn_o,
    output logic                      eot_o
);

    import spim_pkg::*;

    localparam int NUM_CS = `SPIM_NUM_CS;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_BUSY,
        ST_APPLY
    } ctrl_state_e;

    ctrl_state_e  state;
    spim_opcode_e opcode;
    logic         is_xfer;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign cmd_pop_o = (state == ST_IDLE) && !cmd_empty_i;

    // Opcode sits at the same place in both views
    assign opcode  = cmd_i.cfg.opcode;
    assign is_xfer = opcode inside {SEND_CMD, TX_DATA, RX_DATA};

    // Transfer descriptor handed to the shifter
    always_ff @(posedge sys_clk_i)
    begin
        if (cmd_pop_o && is_xfer)
        begin
            if (opcode == SEND_CMD)
                xfer_o.phase <= CMD;
            else if (opcode == TX_DATA)
                xfer_o.phase <= TX;
            else
                xfer_o.phase <= RX;
            xfer_o.qpi      <= cmd_i.xfer.qpi;
            xfer_o.len_m1   <= cmd_i.xfer.len_m1;
            xfer_o.cmd_data <= cmd_i.xfer.cmd_data;
        end
    end

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state        <= ST_IDLE;
            clkdiv_o     <= '0;
            xfer_start_o <= 1'b0;
            spi_csn_o    <= '1;
            eot_o        <= 1'b0;
        end
        else
        begin
            xfer_start_o <= 1'b0;
            eot_o        <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd_pop_o)
                    begin
                        state        <= is_xfer ? ST_BUSY : ST_APPLY;
                        xfer_start_o <= is_xfer;
                        case (opcode)
                            CFG: clkdiv_o <= cmd_i.cfg.clkdiv;
                            SOT: spi_csn_o <= ~(NUM_CS'(1) << cmd_i.xfer.csn_sel);
                            EOT:
                            begin
                                spi_csn_o <= '1;
                                eot_o     <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_BUSY:
                begin
                    if (xfer_done_i)
                        state <= ST_IDLE;
                end
                // One-cycle commands settle here before the next pop
                default: state <= ST_IDLE;
            endcase
        end
    end

    assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) $onehot0(~spi_csn_o))
        else $error("spim_ctrl: more than one chip select low");

    // The shifter only reports done for a transfer this FSM started
    assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
                     xfer_done_i |-> state == ST_BUSY)
        else $error("spim_ctrl: unexpected transfer done");

endmodule

// ==== spim_fifo.sv ====
`timescale 1ns/1ns

module spim_fifo
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
)
(
    input  logic             sys_clk_i,
    input  logic             rst_n_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // Show-ahead: head entry is visible before the pop
    assign data_o = mem[rd_ptr];

    always_ff @(posedge sys_clk_i)
    begin
        if (push_i)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // Producers watch full_o, consumers watch empty_o
    assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
        else $error("spim_fifo: push while full");

    assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
        else $error("spim_fifo: pop while empty");

endmodule

// ==== spim_pkg.sv ====
`include "spim_config.svh"

package spim_pkg;

    typedef enum logic [`SPIM_OPCODE_W-1:0]
    {
        CFG      = 4'h0,
        SOT      = 4'h1,
        SEND_CMD = 4'h2,
        TX_DATA  = 4'h3,
        RX_DATA  = 4'h4,
        EOT      = 4'h5
    } spim_opcode_e;

    // CFG view of a command word
    typedef struct packed
    {
        spim_opcode_e                                          opcode;
        logic [`SPIM_DATA_W-`SPIM_OPCODE_W-`SPIM_CLKDIV_W-1:0] pad;
        logic [`SPIM_CLKDIV_W-1:0]                             clkdiv;
    } spim_cfg_cmd_t;

    // Transfer view, also used by SOT for the chip select
    typedef struct packed
    {
        spim_opcode_e                    opcode;
        logic                            qpi;
        logic [$clog2(`SPIM_NUM_CS)-1:0] csn_sel;
        logic                            pad;
        logic [`SPIM_LEN_W-1:0]          len_m1;
        logic [`SPIM_CMD_W-1:0]          cmd_data;
    } spim_xfer_cmd_t;

    typedef union packed
    {
        spim_cfg_cmd_t  cfg;
        spim_xfer_cmd_t xfer;
    } spim_cmd_u;

    typedef enum logic [1:0]
    {
        CMD = 2'd0,
        TX  = 2'd1,
        RX  = 2'd2
    } spim_phase_e;

    typedef struct packed
    {
        spim_phase_e            phase;
        logic                   qpi;
        logic [`SPIM_LEN_W-1:0] len_m1;
        logic [`SPIM_CMD_W-1:0] cmd_data;
    } spim_xfer_t;

endpackage

// ==== spim_top.sv ====
`timescale 1ns/1ns
`include "spim_config.svh"

module spim_top
(
    input  logic                    sys_clk_i,
    input  logic                    rst_n_i,

    input  logic [`SPIM_DATA_W-1:0] cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_full_o,

    input  logic [`SPIM_DATA_W-1:0] tx_data_i,
    input  logic                    tx_valid_i,
    output logic                    tx_full_o,

    output logic [`SPIM_DATA_W-1:0] rx_data_o,
    output logic                    rx_valid_o,

    output logic                    eot_o,

    output logic                    spi_clk_o,
    output logic [`SPIM_NUM_CS-1:0] spi_csn_o,
    output logic [1:0]              spi_mode_o,
    output logic [3:0]              spi_sdo_o,
    input  logic [3:0]              spi_sdi_i
);

    import spim_pkg::*;

    logic [`SPIM_DATA_W-1:0]   cmd_word;
    logic                      cmd_empty;
    logic                      cmd_pop;

    logic [`SPIM_DATA_W-1:0]   tx_word;
    logic                      tx_empty;
    logic                      tx_pop;

    logic [`SPIM_CLKDIV_W-1:0] clkdiv;
    logic                      spi_run;
    logic                      spi_rise;
    logic                      spi_fall;

    logic                      xfer_start;
    spim_xfer_t                xfer;
    logic                      xfer_done;

    //////////////////////////////
    // Input buffers
    //////////////////////////////

    spim_fifo #(
        .WIDTH ( `SPIM_DATA_W     ),
        .DEPTH ( `SPIM_FIFO_DEPTH )
    ) u_cmd_fifo (
        .sys_clk_i ( sys_clk_i   ),
        .rst_n_i   ( rst_n_i     ),
        .push_i    ( cmd_valid_i ),
        .data_i    ( cmd_i       ),
        .pop_i     ( cmd_pop     ),
        .data_o    ( cmd_word    ),
        .empty_o   ( cmd_empty   ),
        .full_o    ( cmd_full_o  )
    );

    spim_fifo #(
        .WIDTH ( `SPIM_DATA_W     ),
        .DEPTH ( `SPIM_FIFO_DEPTH )
    ) u_tx_fifo (
        .sys_clk_i ( sys_clk_i  ),
        .rst_n_i   ( rst_n_i    ),
        .push_i    ( tx_valid_i ),
        .data_i    ( tx_data_i  ),
        .pop_i     ( tx_pop     ),
        .data_o    ( tx_word    ),
        .empty_o   ( tx_empty   ),
        .full_o    ( tx_full_o  )
    );

    //////////////////////////////
    // SPI engine
    //////////////////////////////

    spim_clkgen u_clkgen (
        .sys_clk_i ( sys_clk_i ),
        .rst_n_i   ( rst_n_i   ),
        .clkdiv_i  ( clkdiv    ),
        .run_i     ( spi_run   ),
        .spi_clk_o ( spi_clk_o ),
        .rise_o    ( spi_rise  ),
        .fall_o    ( spi_fall  )
    );

    spim_ctrl u_ctrl (
        .sys_clk_i    ( sys_clk_i  ),
        .rst_n_i      ( rst_n_i    ),
        .cmd_i        ( cmd_word   ),
        .cmd_empty_i  ( cmd_empty  ),
        .cmd_pop_o    ( cmd_pop    ),
        .clkdiv_o     ( clkdiv     ),
        .xfer_start_o ( xfer_start ),
        .xfer_o       ( xfer       ),
        .xfer_done_i  ( xfer_done  ),
        .spi_csn_o    ( spi_csn_o  ),
        .eot_o        ( eot_o      )
    );

    spim_txrx u_txrx (
        .sys_clk_i  ( sys_clk_i  ),
        .rst_n_i    ( rst_n_i    ),
        .start_i    ( xfer_start ),
        .xfer_i     ( xfer       ),
        .done_o     ( xfer_done  ),
        .tx_data_i  ( tx_word    ),
        .tx_empty_i ( tx_empty   ),
        .tx_pop_o   ( tx_pop     ),
        .rx_data_o  ( rx_data_o  ),
        .rx_valid_o ( rx_valid_o ),
        .run_o      ( spi_run    ),
        .rise_i     ( spi_rise   ),
        .fall_i     ( spi_fall   ),
        .spi_mode_o ( spi_mode_o ),
        .spi_sdo_o  ( spi_sdo_o  ),
        .spi_sdi_i  ( spi_sdi_i  )
    );

endmodule

// ==== spim_txrx.sv ====
`timescale 1ns/1ns
`include "spim_config.svh"

module spim_txrx
(
    input  logic                    sys_clk_i,
    input  logic                    rst_n_i,

    input  logic                    start_i,
    input  spim_pkg::spim_xfer_t    xfer_i,
    output logic                    done_o,

    input  logic [`SPIM_DATA_W-1:0] tx_data_i,
    input  logic                    tx_empty_i,
    output logic                    tx_pop_o,

    output logic [`SPIM_DATA_W-1:0] rx_data_o,
    output logic                    rx_valid_o,

    output logic                    run_o,
    input  logic                    rise_i,
    input  logic                    fall_i,

    output logic [1:0]              spi_mode_o,
    output logic [3:0]              spi_sdo_o,
    input  logic [3:0]              spi_sdi_i
);

    import spim_pkg::*;

    localparam int SLOT_W = $clog2(`SPIM_DATA_W);
    localparam int PAD_W  = `SPIM_DATA_W - `SPIM_CMD_W;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT
    } txrx_state_e;

    txrx_state_e             state;
    spim_xfer_t              xfer_q;
    logic [`SPIM_DATA_W-1:0] shift_q;
    logic [SLOT_W-1:0]       slot_cnt;
    logic [`SPIM_LEN_W-1:0]  word_cnt;
    logic [SLOT_W-1:0]       slots_m1;
    logic                    load_ok;
    logic                    word_end;

    // Slots per word minus one, a slot is 1 bit or a quad nibble
    always_comb
    begin
        if (xfer_q.phase == CMD)
            slots_m1 = xfer_q.qpi ? SLOT_W'(xfer_q.len_m1[3:2]) : SLOT_W'(xfer_q.len_m1[3:0]);
        else
            slots_m1 = xfer_q.qpi ? SLOT_W'(`SPIM_DATA_W / 4 - 1) : SLOT_W'(`SPIM_DATA_W - 1);
    end

    // TX words wait here for the FIFO, with the SPI clock parked
    assign load_ok  = (state == ST_LOAD) && ((xfer_q.phase != TX) || !tx_empty_i);
    assign tx_pop_o = load_ok && (xfer_q.phase == TX);
    assign word_end = (state == ST_SHIFT) && fall_i && (slot_cnt == '0);
    assign run_o    = (state == ST_SHIFT);

    assign rx_data_o = shift_q;

    //////////////////////////////
    // Pad direction and data
    //////////////////////////////

    always_comb
    begin
        spi_mode_o = 2'd0;
        spi_sdo_o  = 4'b0000;
        if (xfer_q.phase != RX)
            spi_sdo_o = xfer_q.qpi ? shift_q[`SPIM_DATA_W-1 -: 4]
                                   : {3'b000, shift_q[`SPIM_DATA_W-1]};
        if (state != ST_IDLE && xfer_q.qpi)
            spi_mode_o = (xfer_q.phase == RX) ? 2'd2 : 2'd1;
    end

    //////////////////////////////
    // Shift register
    //////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (start_i)
            xfer_q <= xfer_i;

        // MSB first, out on falling edges and in on rising edges
        if (load_ok)
            shift_q <= (xfer_q.phase == TX) ? tx_data_i : {xfer_q.cmd_data, PAD_W'(0)};
        else if (run_o && rise_i && xfer_q.phase == RX)
            shift_q <= xfer_q.qpi ? {shift_q[`SPIM_DATA_W-5:0], spi_sdi_i}
                                  : {shift_q[`SPIM_DATA_W-2:0], spi_sdi_i[1]};
        else if (run_o && fall_i && xfer_q.phase != RX && slot_cnt != '0)
            shift_q <= xfer_q.qpi ? {shift_q[`SPIM_DATA_W-5:0], 4'b0000}
                                  : {shift_q[`SPIM_DATA_W-2:0], 1'b0};
    end

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state      <= ST_IDLE;
            slot_cnt   <= '0;
            word_cnt   <= '0;
            done_o     <= 1'b0;
            rx_valid_o <= 1'b0;
        end
        else
        begin
            done_o     <= 1'b0;
            rx_valid_o <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start_i)
                    begin
                        // A command field is always one word
                        word_cnt <= (xfer_i.phase == CMD) ? '0 : xfer_i.len_m1;
                        state    <= ST_LOAD;
                    end
                end
                ST_LOAD:
                begin
                    if (load_ok)
                    begin
                        slot_cnt <= slots_m1;
                        state    <= ST_SHIFT;
                    end
                end
                ST_SHIFT:
                begin
                    if (word_end)
                    begin
                        rx_valid_o <= (xfer_q.phase == RX);
                        if (word_cnt != '0)
                        begin
                            word_cnt <= word_cnt - 1'b1;
                            state    <= ST_LOAD;
                        end
                        else
                        begin
                            done_o <= 1'b1;
                            state  <= ST_IDLE;
                        end
                    end
                    else if (fall_i)
                    begin
                        slot_cnt <= slot_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assert property (@(posedge sys_clk_i) disable iff (!rst_n_i) start_i |-> state == ST_IDLE)
        else $error("spim_txrx: start while a transfer is running");

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen
#(
    parameter int PERIOD_NS = 4
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// ==== tb_spi_device.sv ====
`timescale 1ns/1ns

module tb_spi_device
(
    input  logic        spi_clk_i,
    input  logic [3:0]  spi_csn_i,
    input  logic [1:0]  spi_mode_i,
    input  logic [3:0]  spi_sdo_i,
    output logic [3:0]  spi_sdi_o,

    input  logic        load_i,
    input  logic [63:0] pattern_i,
    output logic [63:0] cap_data_o,
    output logic [7:0]  cap_bits_o,
    output logic [3:0]  cap_csn_o
);

    logic [63:0] pattern;
    logic        selected;

    assign selected = (spi_csn_i != 4'hf);

    // Quad read drives a nibble on lines 3 to 0, single read uses line 1
    assign spi_sdi_o = !selected          ? 4'b0000 :
                       (spi_mode_i == 2'd2) ? pattern[63:60] :
                                            {2'b00, pattern[63], 1'b0};

    // Mode 0 device, next read bit goes out on the falling edge
    always @(negedge spi_clk_i or posedge load_i)
    begin
        if (load_i)
            pattern <= pattern_i;
        else if (selected)
            pattern <= (spi_mode_i == 2'd2) ? {pattern[59:0], 4'h0} : {pattern[62:0], 1'b0};
    end

    // Capture on the rising edge
    always @(posedge spi_clk_i or posedge load_i)
    begin
        if (load_i)
        begin
            cap_data_o <= '0;
            cap_bits_o <= '0;
            cap_csn_o  <= '1;
        end
        else if (selected)
        begin
            cap_csn_o <= spi_csn_i;
            if (spi_mode_i == 2'd1)
            begin
                cap_data_o <= {cap_data_o[59:0], spi_sdo_i};
                cap_bits_o <= cap_bits_o + 8'd4;
            end
            else
            begin
                cap_data_o <= {cap_data_o[62:0], spi_sdo_i[0]};
                cap_bits_o <= cap_bits_o + 8'd1;
            end
        end
    end

endmodule

// ==== tb_spim.sv ====
`timescale 1ns/1ns
`include "spim_config.svh"

module tb_spim;

    import spim_pkg::*;

    localparam int TIMEOUT = 1000;

    logic                    sys_clk;
    logic                    rst_n;
    logic [`SPIM_DATA_W-1:0] cmd;
    logic                    cmd_valid;
    logic                    cmd_full;
    logic [`SPIM_DATA_W-1:0] tx_data;
    logic                    tx_valid;
    logic                    tx_full;
    logic [`SPIM_DATA_W-1:0] rx_data;
    logic                    rx_valid;
    logic                    eot;
    logic                    spi_clk;
    logic [`SPIM_NUM_CS-1:0] spi_csn;
    logic [1:0]              spi_mode;
    logic [3:0]              spi_sdo;
    logic [3:0]              spi_sdi;

    logic                    dev_load;
    logic [63:0]             dev_pattern;
    logic [63:0]             cap_data;
    logic [7:0]              cap_bits;
    logic [3:0]              cap_csn;

    int                      errors;
    int                      tests;
    logic [`SPIM_DATA_W-1:0] rx_words [$];
    int                      high_runs [$];
    logic [3:0]              modes_seen;

    tb_clkgen #(.PERIOD_NS(4)) u_clk (.clk_o(sys_clk));

    spim_top spim_top_inst (
        .sys_clk_i   ( sys_clk   ),
        .rst_n_i     ( rst_n     ),
        .cmd_i       ( cmd       ),
        .cmd_valid_i ( cmd_valid ),
        .cmd_full_o  ( cmd_full  ),
        .tx_data_i   ( tx_data   ),
        .tx_valid_i  ( tx_valid  ),
        .tx_full_o   ( tx_full   ),
        .rx_data_o   ( rx_data   ),
        .rx_valid_o  ( rx_valid  ),
        .eot_o       ( eot       ),
        .spi_clk_o   ( spi_clk   ),
        .spi_csn_o   ( spi_csn   ),
        .spi_mode_o  ( spi_mode  ),
        .spi_sdo_o   ( spi_sdo   ),
        .spi_sdi_i   ( spi_sdi   )
    );

    tb_spi_device u_device (
        .spi_clk_i  ( spi_clk     ),
        .spi_csn_i  ( spi_csn     ),
        .spi_mode_i ( spi_mode    ),
        .spi_sdo_i  ( spi_sdo     ),
        .spi_sdi_o  ( spi_sdi     ),
        .load_i     ( dev_load    ),
        .pattern_i  ( dev_pattern ),
        .cap_data_o ( cap_data    ),
        .cap_bits_o ( cap_bits    ),
        .cap_csn_o  ( cap_csn     )
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Transfer and SOT layout is opcode, qpi, csn_sel, pad, len_m1 and cmd_data
    function automatic logic [31:0] xfer_word(input logic [3:0] op, input logic qpi,
                                              input logic [1:0] cs, input logic [7:0] len_m1,
                                              input logic [15:0] data);
        return {op, qpi, cs, 1'b0, len_m1, data};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("FAILED %s", what);
    endtask

    task automatic push_command(input logic [31:0] word);
        int cyc;
        @(negedge sys_clk);
        for (cyc = 0; cyc < TIMEOUT && cmd_full; cyc++)
            @(negedge sys_clk);
        if (cmd_full)
            report_failure("command FIFO stayed full");
        @(posedge sys_clk);
        cmd       <= word;
        cmd_valid <= 1'b1;
        @(posedge sys_clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic push_tx_word(input logic [31:0] word);
        int cyc;
        @(negedge sys_clk);
        for (cyc = 0; cyc < TIMEOUT && tx_full; cyc++)
            @(negedge sys_clk);
        if (tx_full)
            report_failure("TX FIFO stayed full");
        @(posedge sys_clk);
        tx_data  <= word;
        tx_valid <= 1'b1;
        @(posedge sys_clk);
        tx_valid <= 1'b0;
    endtask

    // New read pattern that also clears the device capture
    task automatic load_device(input logic [63:0] pattern);
        @(posedge sys_clk);
        dev_pattern <= pattern;
        @(posedge sys_clk);
        dev_load <= 1'b1;
        @(posedge sys_clk);
        dev_load <= 1'b0;
    endtask

    // Watches the bus up to the EOT pulse and records RX words,
    // SPI clock high phases and pad modes seen while the clock is high
    task automatic wait_for_eot(input string name);
        int   cyc;
        int   run_len;
        int   extra;
        logic prev_clk;

        rx_words.delete();
        high_runs.delete();
        modes_seen = 4'b0000;
        run_len    = 0;
        extra      = 0;
        prev_clk   = 1'b1;
        for (cyc = 0; cyc < TIMEOUT; cyc++)
        begin
            @(negedge sys_clk);
            if (rx_valid)
                rx_words.push_back(rx_data);
            if (spi_clk)
                modes_seen[spi_mode] = 1'b1;
            // A high phase already running at the start is not counted
            if (spi_clk && !prev_clk)
                run_len = 1;
            else if (spi_clk && run_len != 0)
                run_len++;
            else if (!spi_clk && run_len != 0)
            begin
                high_runs.push_back(run_len);
                run_len = 0;
            end
            prev_clk = spi_clk;
            if (eot)
                break;
        end
        if (!eot)
            report_failure($sformatf("%s: no eot_o pulse within %0d cycles", name, TIMEOUT));
        repeat (8)
        begin
            @(negedge sys_clk);
            if (eot)
                extra++;
        end
        if (extra != 0)
            report_mismatch({name, " eot_o high cycles"}, 64'd1, 64'(1 + extra));
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic after_reset();
        tests++;
        @(negedge sys_clk);
        if (spi_csn !== 4'hf)
            report_mismatch("after_reset spi_csn_o", 64'hf, 64'(spi_csn));
        if (spi_clk !== 1'b0)
            report_mismatch("after_reset spi_clk_o", 64'd0, 64'(spi_clk));
        if (eot !== 1'b0)
            report_mismatch("after_reset eot_o", 64'd0, 64'(eot));
        if (rx_valid !== 1'b0)
            report_mismatch("after_reset rx_valid_o", 64'd0, 64'(rx_valid));
        if (spi_mode !== 2'd0)
            report_mismatch("after_reset spi_mode_o", 64'd0, 64'(spi_mode));
        if (cmd_full !== 1'b0 || tx_full !== 1'b0)
            report_mismatch("after_reset full flags", 64'd0, 64'({cmd_full, tx_full}));
    endtask

    task automatic chip_selects();
        int         sel;
        int         cyc;
        logic [3:0] exp_csn;
        tests++;
        for (sel = 0; sel < 4; sel++)
        begin
            // Only the selected line is low
            case (sel)
                0:       exp_csn = 4'b1110;
                1:       exp_csn = 4'b1101;
                2:       exp_csn = 4'b1011;
                default: exp_csn = 4'b0111;
            endcase
            push_command(xfer_word(SOT, 1'b0, 2'(sel), 8'h00, 16'h0000));
            @(negedge sys_clk);
            for (cyc = 0; cyc < TIMEOUT && spi_csn === 4'hf; cyc++)
                @(negedge sys_clk);
            if (spi_csn === 4'hf)
                report_failure($sformatf("chip_selects: csn_sel %0d never went low", sel));
            else if (spi_csn !== exp_csn)
                report_mismatch($sformatf("chip_selects csn_sel %0d", sel),
                                64'(exp_csn), 64'(spi_csn));
            push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
            wait_for_eot("chip_selects");
            if (spi_csn !== 4'hf)
                report_mismatch("chip_selects csn after EOT", 64'hf, 64'(spi_csn));
        end
    endtask

    task automatic send_command();
        logic [15:0] data;
        tests++;
        data = 16'($urandom);
        load_device(64'h0);
        push_command(xfer_word(SOT, 1'b0, 2'd1, 8'h00, 16'h0000));
        push_command(xfer_word(SEND_CMD, 1'b0, 2'd1, 8'd7, data));
        push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        wait_for_eot("send_command");
        if (cap_bits !== 8'd8)
            report_mismatch("send_command bit count", 64'd8, 64'(cap_bits));
        if (cap_data[7:0] !== data[15:8])
            report_mismatch("send_command bits", 64'(data[15:8]), 64'(cap_data[7:0]));
        if (cap_csn !== 4'b1101)
            report_mismatch("send_command chip select", 64'hd, 64'(cap_csn));
    endtask

    task automatic quad_write();
        logic [31:0] w0;
        logic [31:0] w1;
        tests++;
        w0 = $urandom;
        w1 = $urandom;
        load_device(64'h0);
        push_tx_word(w0);
        push_tx_word(w1);
        push_command(xfer_word(SOT, 1'b0, 2'd2, 8'h00, 16'h0000));
        push_command(xfer_word(TX_DATA, 1'b1, 2'd2, 8'd1, 16'h0000));
        push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        wait_for_eot("quad_write");
        if (cap_bits !== 8'd64)
            report_mismatch("quad_write bit count", 64'd64, 64'(cap_bits));
        if (cap_data !== {w0, w1})
            report_mismatch("quad_write data", {w0, w1}, cap_data);
        if (modes_seen !== 4'b0010)
            report_mismatch("quad_write spi_mode_o set", 64'b0010, 64'(modes_seen));
    endtask

    task automatic read_words();
        logic [31:0] p0;
        logic [31:0] p1;
        logic [31:0] p2;
        tests++;
        p0 = $urandom;
        p1 = $urandom;
        p2 = $urandom;

        // Single line with one word
        load_device({p0, 32'h0});
        push_command(xfer_word(SOT, 1'b0, 2'd3, 8'h00, 16'h0000));
        push_command(xfer_word(RX_DATA, 1'b0, 2'd3, 8'd0, 16'h0000));
        push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        wait_for_eot("read_words single");
        if (rx_words.size() != 1)
            report_mismatch("read_words single count", 64'd1, 64'(rx_words.size()));
        else if (rx_words[0] !== p0)
            report_mismatch("read_words single word", 64'(p0), 64'(rx_words[0]));

        // Quad lines with two words
        load_device({p1, p2});
        push_command(xfer_word(SOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        push_command(xfer_word(RX_DATA, 1'b1, 2'd0, 8'd1, 16'h0000));
        push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        wait_for_eot("read_words quad");
        if (rx_words.size() != 2)
            report_mismatch("read_words quad count", 64'd2, 64'(rx_words.size()));
        else
        begin
            if (rx_words[0] !== p1)
                report_mismatch("read_words quad word 0", 64'(p1), 64'(rx_words[0]));
            if (rx_words[1] !== p2)
                report_mismatch("read_words quad word 1", 64'(p2), 64'(rx_words[1]));
        end
    endtask

    task automatic divider_setting();
        tests++;
        load_device(64'h0);
        push_command({CFG, 20'h00000, 8'd3});
        push_command(xfer_word(SOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        push_command(xfer_word(SEND_CMD, 1'b0, 2'd0, 8'd7, 16'h5a00));
        push_command(xfer_word(EOT, 1'b0, 2'd0, 8'h00, 16'h0000));
        wait_for_eot("divider_setting");
        // Half period is clkdiv + 1 system cycles
        if (high_runs.size() != 8)
            report_mismatch("divider_setting high phases", 64'd8, 64'(high_runs.size()));
        foreach (high_runs[i])
        begin
            if (high_runs[i] != 4)
                report_mismatch($sformatf("divider_setting high phase %0d", i),
                                64'd4, 64'(high_runs[i]));
        end
    endtask

    //////////////////////////////
    // Sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(32'hd0066b88));
        errors      = 0;
        tests       = 0;
        rst_n       = 1'b0;
        cmd         = '0;
        cmd_valid   = 1'b0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        dev_load    = 1'b0;
        dev_pattern = '0;

        repeat (3) @(posedge sys_clk);
        rst_n <= 1'b1;

        after_reset();
        chip_selects();
        send_command();
        quad_write();
        read_words();
        divider_setting();

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
